// File: src.f
cpu_pkg.sv
alu.sv
reg_file.sv
fetch_unit.sv
issue_stage.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
tb_checker.sv
tb_cpu.sv

// File: Makefile
TOP        ?= tb_cpu
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
	import cpu_pkg::*;
();

	localparam int DATA_W = 16;
	localparam logic [DATA_W-1:0] RESET_PC = '0;
	localparam int MAX_CYCLES = 20000;
	localparam int DRAIN_CYCLES = 40;

	logic     CLK;
	logic     RSTb;
	word_t    mem_rdata;
	mem_req_t mem_req;
	mem_req_t req_s;
	word_t    mem [65536];
	word_t    ref_mem [65536];
	word_t    prog [$];
	word_t    exp_addr [$];
	word_t    exp_data [$];
	integer   seed;
	int       cycles;
	logic     timed_out;

	cpu_top #(
		.DATA_W  (DATA_W),
		.RESET_PC(RESET_PC)
	) u_cpu_top (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.mem_rdata(mem_rdata),
		.mem_req  (mem_req)
	);

	tb_checker u_checker (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.mem_req(mem_req)
	);

	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

	// memory model, request sampled mid-cycle and served just after the edge
	always @(negedge CLK) req_s = mem_req;

	always @(posedge CLK) begin
		#1;
		mem_rdata = mem[req_s.addr];
		if (RSTb && req_s.we)
			mem[req_s.addr] = req_s.wdata;
	end

	function automatic word_t enc_rr(input logic b11, input logic [2:0] op,
		input reg_idx_t d, input reg_idx_t s);
		return {4'h2, b11, op, d, s};
	endfunction

	function automatic word_t enc_ri(input logic [2:0] op, input reg_idx_t d,
		input logic [3:0] nib);
		return {4'h3, 1'b0, op, d, nib};
	endfunction

	task automatic emit(input word_t w);
		prog.push_back(w);
	endtask

	// prefix plus pass of the immediate
	task automatic emit_const(input reg_idx_t r, input word_t v);
		emit({4'h1, v[15:4]});
		emit(enc_ri(3'd7, r, v[3:0]));
	endtask

	task automatic emit_store_at(input reg_idx_t r, input word_t a);
		emit({4'h1, a[15:4]});
		emit({4'h6, 4'h1, r, a[3:0]});
	endtask

	task automatic emit_load_from(input reg_idx_t r, input word_t a);
		emit({4'h1, a[15:4]});
		emit({4'h6, 4'h0, r, a[3:0]});
	endtask

	task automatic build_program();
		logic [31:0] pick;
		reg_idx_t    d;
		reg_idx_t    s;
		// every alu op in register-register form
		emit_const(4'd1, 16'h1234);
		emit_const(4'd2, 16'h00f3);
		for (int k = 0; k < 8; k++) begin
			emit(enc_rr(1'b0, 3'd7, 4'd3, 4'd1));
			emit(enc_rr(1'b0, 3'(k), 4'd3, 4'd2));
			emit_store_at(4'd3, 16'h9000 + 16'(k));
		end
		// immediates without prefix, with prefix, then prefix cleared
		emit(enc_ri(3'd7, 4'd4, 4'h5));
		emit({4'h1, 12'h012});
		emit(enc_ri(3'd0, 4'd4, 4'h7));
		emit(enc_ri(3'd0, 4'd4, 4'h3));
		emit_store_at(4'd4, 16'h9010);
		// dependent chain through inc, dec and the alu
		emit_const(4'd10, 16'h0007);
		emit({8'h02, 4'h0, 4'd10});
		emit({8'h02, 4'h0, 4'd10});
		emit({8'h03, 4'h0, 4'd10});
		emit(enc_rr(1'b0, 3'd0, 4'd10, 4'd10));
		emit(enc_rr(1'b0, 3'd7, 4'd11, 4'd10));
		emit(enc_rr(1'b0, 3'd5, 4'd11, 4'd11));
		emit_store_at(4'd10, 16'h9011);
		emit_store_at(4'd11, 16'h9012);
		// loads, used right away
		emit_load_from(4'd6, 16'h8001);
		emit_store_at(4'd6, 16'h9020);
		emit_const(4'd7, 16'h8005);
		emit({4'h5, 4'h0, 4'd8, 4'd7});
		emit_const(4'd9, 16'h9030);
		emit({4'h5, 4'h1, 4'd8, 4'd9});
		// random block
		for (int n = 0; n < 48; n++) begin
			pick = $random(seed);
			d = pick[7:4];
			s = pick[11:8];
			case (pick[30:28])
				3'd2: begin
					if (pick[21])
						emit({4'h1, pick[27:16]});
					emit(enc_ri(pick[14:12], d, pick[19:16]));
				end
				3'd3: emit({4'h0, 3'b001, pick[22], 4'h0, s});
				3'd4: emit_load_from(d, {8'h80, pick[27:20]});
				3'd5: emit_store_at(d, {8'h91, pick[27:20]});
				default: emit(enc_rr(pick[20], pick[14:12], d, s));
			endcase
		end
		// dump the whole register file at the end
		for (int r = 0; r < 16; r++)
			emit_store_at(4'(r), 16'h9f00 + 16'(r));
	endtask

	function automatic word_t alu_ref(input logic [2:0] op, input word_t a, input word_t b);
		case (op)
			3'd0: return a + b;
			3'd1: return a - b;
			3'd2: return a & b;
			3'd3: return a | b;
			3'd4: return a ^ b;
			3'd5: return a << 1;
			3'd6: return a >> 1;
			default: return b;
		endcase
	endfunction

	// architectural model, in program order
	function automatic void run_reference();
		word_t       regs [16];
		logic [11:0] pfx;
		word_t       w;
		word_t       a;
		reg_idx_t    d;
		reg_idx_t    s;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		pfx = '0;
		foreach (prog[pc]) begin
			w = prog[pc];
			d = w[7:4];
			s = w[3:0];
			case (w[15:12])
				4'h0: begin
					if (w[11:8] == 4'h2) begin
						regs[s] = regs[s] + 16'd1;
						pfx = '0;
					end else if (w[11:8] == 4'h3) begin
						regs[s] = regs[s] - 16'd1;
						pfx = '0;
					end
				end
				4'h1: pfx = w[11:0];
				4'h2: begin
					regs[d] = alu_ref(w[10:8], regs[d], regs[s]);
					pfx = '0;
				end
				4'h3: begin
					regs[d] = alu_ref(w[10:8], regs[d], {pfx, w[3:0]});
					pfx = '0;
				end
				4'h5, 4'h6: begin
					a = (w[15:12] == 4'h5) ? regs[s] : {pfx, w[3:0]};
					if (w[8]) begin
						ref_mem[a] = regs[d];
						exp_addr.push_back(a);
						exp_data.push_back(regs[d]);
					end else begin
						regs[d] = ref_mem[a];
					end
					pfx = '0;
				end
				default: ;
			endcase
		end
	endfunction

	initial begin
		seed = 32'h0e44_01b8;
		RSTb = 1'b0;
		mem_rdata = '0;
		req_s = '0;
		timed_out = 1'b0;
		cycles = 0;
		// data area pattern, nop everywhere below it
		for (int a = 0; a < 65536; a++)
			mem[a] = (a >= 32'h8000) ? word_t'(a * 32'h9e37 + 32'h01b3) : '0;
		build_program();
		foreach (prog[i])
			mem[i] = prog[i];
		for (int a = 0; a < 65536; a++)
			ref_mem[a] = mem[a];
		run_reference();
		foreach (exp_addr[i])
			u_checker.push_expected(exp_addr[i], exp_data[i]);

		repeat (4) @(posedge CLK);
		#1 RSTb = 1'b1;

		while (u_checker.store_count < exp_addr.size() && !timed_out) begin
			@(posedge CLK);
			cycles++;
			if (cycles > MAX_CYCLES)
				timed_out = 1'b1;
		end
		if (timed_out)
			$display("timeout: only %0d of %0d stores seen after %0d cycles",
				u_checker.store_count, exp_addr.size(), cycles);
		// extra time to catch stray stores
		for (int i = 0; i < DRAIN_CYCLES; i++)
			@(posedge CLK);

		u_checker.report(timed_out);
		if (!timed_out && u_checker.error_count() == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
	import cpu_pkg::*;
(
	input wire logic     CLK,
	input wire logic     RSTb,
	input wire mem_req_t mem_req
);

	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	word_t want_a;
	word_t want_d;
	int    store_count;
	int    mismatch_count;
	int    extra_count;
	int    reset_errors;
	logic  first_seen;

	initial begin
		store_count = 0;
		mismatch_count = 0;
		extra_count = 0;
		reset_errors = 0;
		first_seen = 1'b0;
	end

	function automatic void push_expected(input word_t a, input word_t d);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endfunction

	// stores still queued count as missing
	function automatic int error_count();
		return mismatch_count + extra_count + reset_errors + exp_addr_q.size();
	endfunction

	// sampled mid-cycle where the request is settled
	always @(negedge CLK) begin
		if (RSTb) begin
			if (!first_seen) begin
				first_seen = 1'b1;
				if (mem_req.addr !== 16'h0000) begin
					$display("Mismatch: mem_req.addr after reset got %h expected %h",
						mem_req.addr, 16'h0000);
					reset_errors++;
				end
				if (mem_req.we !== 1'b0) begin
					$display("Mismatch: mem_req.we after reset got %h expected %h",
						mem_req.we, 1'b0);
					reset_errors++;
				end
			end
			if (mem_req.we === 1'b1) begin
				store_count++;
				if (exp_addr_q.size() == 0) begin
					$display("store to %h with data %h when no more stores were expected",
						mem_req.addr, mem_req.wdata);
					extra_count++;
				end else begin
					want_a = exp_addr_q.pop_front();
					want_d = exp_data_q.pop_front();
					if (mem_req.addr !== want_a) begin
						$display("Mismatch: mem_req.addr got %h expected %h",
							mem_req.addr, want_a);
						mismatch_count++;
					end
					if (mem_req.wdata !== want_d) begin
						$display("Mismatch: mem_req.wdata at %h got %h expected %h",
							want_a, mem_req.wdata, want_d);
						mismatch_count++;
					end
				end
			end
		end
	end

	task automatic report(input logic timed_out);
		$display("stores %0d, mismatches %0d, unexpected %0d, missing %0d, reset %0d, timeout %0d",
			store_count, mismatch_count, extra_count, exp_addr_q.size(), reset_errors,
			timed_out);
	endtask

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter logic [DATA_W-1:0] RESET_PC = '0
) (
	input  wire logic  CLK,
	input  wire logic  RSTb,
	input  wire word_t mem_rdata,
	output mem_req_t   mem_req
);

	word_t    fetch_addr;
	word_t    instr;
	logic     stall;
	logic     port_busy;
	logic     load_return;
	reg_idx_t rd_a;
	reg_idx_t rd_b;
	issue_t   issued;
	word_t    data_a;
	word_t    data_b;
	ex_t      stage3;
	wb_t      wb;

	fetch_unit #(
		.DATA_W  (DATA_W),
		.RESET_PC(RESET_PC)
	) u_fetch_unit (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.mem_rdata  (mem_rdata),
		.stall      (stall),
		.port_busy  (port_busy),
		.load_return(load_return),
		.fetch_addr (fetch_addr),
		.instr      (instr)
	);

	issue_stage #(
		.DATA_W(DATA_W)
	) u_issue_stage (
		.CLK   (CLK),
		.RSTb  (RSTb),
		.instr (instr),
		.stall (stall),
		.rd_a  (rd_a),
		.rd_b  (rd_b),
		.issued(issued)
	);

	reg_file #(
		.DATA_W(DATA_W)
	) u_reg_file (
		.CLK   (CLK),
		.RSTb  (RSTb),
		.rd_a  (rd_a),
		.rd_b  (rd_b),
		.wb    (wb),
		.data_a(data_a),
		.data_b(data_b)
	);

	execute_stage #(
		.DATA_W(DATA_W)
	) u_execute_stage (
		.CLK   (CLK),
		.RSTb  (RSTb),
		.issued(issued),
		.data_a(data_a),
		.data_b(data_b),
		.stage3(stage3)
	);

	mem_wb_stage #(
		.DATA_W(DATA_W)
	) u_mem_wb_stage (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.stage3     (stage3),
		.fetch_addr (fetch_addr),
		.mem_rdata  (mem_rdata),
		.mem_req    (mem_req),
		.port_busy  (port_busy),
		.load_return(load_return),
		.wb         (wb)
	);

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  wire logic  CLK,
	input  wire logic  RSTb,
	input  wire ex_t   stage3,
	input  wire word_t fetch_addr,
	input  wire word_t mem_rdata,
	output mem_req_t   mem_req,
	output logic       port_busy,
	output logic       load_return,
	output wb_t        wb
);

	ex_t               stage4_q;
	logic              arith4;
	logic [DATA_W-1:0] wb_data;

	// data access in stage 3 steals the port from fetch
	assign port_busy     = (stage3.cls == OP_MEM_REG) || (stage3.cls == OP_MEM_IMM);
	assign mem_req.addr  = port_busy ? stage3.addr : fetch_addr;
	assign mem_req.wdata = stage3.sdata;
	assign mem_req.we    = port_busy && stage3.store;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			stage4_q.cls <= OP_NOP;
		else
			stage4_q <= stage3;
	end

	// the word coming back after any data access is not an instruction
	assign load_return = (stage4_q.cls == OP_MEM_REG) || (stage4_q.cls == OP_MEM_IMM);

	assign arith4 = (stage4_q.cls == OP_INC) || (stage4_q.cls == OP_DEC) ||
		(stage4_q.cls == OP_ALU_RR) || (stage4_q.cls == OP_ALU_RI);

	// load data straight off the port
	assign wb_data = load_return ? mem_rdata : stage4_q.result;
	assign wb.en   = arith4 || (load_return && !stage4_q.store);
	assign wb.idx  = stage4_q.dest;
	assign wb.data = wb_data;

	// a store puts out a settled address and data word
	a_store_known: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_req.we |-> !$isunknown({mem_req.addr, mem_req.wdata}));

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  wire logic   CLK,
	input  wire logic   RSTb,
	input  wire issue_t issued,
	input  wire word_t  data_a,
	input  wire word_t  data_b,
	output ex_t         stage3
);

	logic [DATA_W-1:0] alu_b;
	word_t             alu_y;
	ex_t               ex_next;

	// register-immediate form swaps B for the immediate
	assign alu_b = (issued.cls == OP_ALU_RI) ? issued.imm : data_b;

	alu #(
		.DATA_W(DATA_W)
	) u_alu (
		.op(issued.alu_op),
		.a (data_a),
		.b (alu_b),
		.y (alu_y)
	);

	always_comb begin
		ex_next.cls   = issued.cls;
		ex_next.dest  = issued.dest;
		ex_next.store = issued.store;
		ex_next.sdata = data_a;
		ex_next.addr  = (issued.cls == OP_MEM_REG) ? data_b : issued.imm;
		case (issued.cls)
			OP_INC: ex_next.result = data_a + {{(DATA_W-1){1'b0}}, 1'b1};
			OP_DEC: ex_next.result = data_a - {{(DATA_W-1){1'b0}}, 1'b1};
			default: ex_next.result = alu_y;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			stage3.cls <= OP_NOP;
		else
			stage3 <= ex_next;
	end

endmodule

`default_nettype wire

// File: issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  wire logic  CLK,
	input  wire logic  RSTb,
	input  wire word_t instr,
	output logic       stall,
	output reg_idx_t   rd_a,
	output reg_idx_t   rd_b,
	output issue_t     issued
);

	op_class_e         cls;
	reg_idx_t          fld_d;
	reg_idx_t          fld_s;
	reg_idx_t          dst;
	logic              use_a;
	logic              use_b;
	logic              writes;
	logic [DATA_W-5:0] prefix_q;
	logic [15:0]       pend2_q;
	logic [15:0]       pend3_q;
	logic [15:0]       pend4_q;
	logic [15:0]       rd_mask;
	logic [15:0]       pending;
	issue_t            next_issue;

	// class from the top nibble, class 0 also looks at [11:8]
	always_comb begin
		cls = OP_NOP;
		case (instr[15:12])
			4'h0: begin
				if (instr[11:8] == 4'h2)
					cls = OP_INC;
				else if (instr[11:8] == 4'h3)
					cls = OP_DEC;
			end
			4'h1: cls = OP_IMM;
			4'h2: cls = OP_ALU_RR;
			4'h3: cls = OP_ALU_RI;
			4'h5: cls = OP_MEM_REG;
			4'h6: cls = OP_MEM_IMM;
			default: cls = OP_NOP;
		endcase
	end

	// register fields, bit 8 marks a store
	always_comb begin
		fld_d  = instr[7:4];
		fld_s  = instr[3:0];
		rd_a   = fld_d;
		rd_b   = fld_s;
		dst    = fld_d;
		use_a  = 1'b0;
		use_b  = 1'b0;
		writes = 1'b0;
		case (cls)
			OP_INC, OP_DEC: begin
				rd_a   = fld_s;
				dst    = fld_s;
				use_a  = 1'b1;
				writes = 1'b1;
			end
			OP_ALU_RR: begin
				use_a  = 1'b1;
				use_b  = 1'b1;
				writes = 1'b1;
			end
			OP_ALU_RI: begin
				use_a  = 1'b1;
				writes = 1'b1;
			end
			OP_MEM_REG: begin
				use_a  = instr[8];
				use_b  = 1'b1;
				writes = !instr[8];
			end
			OP_MEM_IMM: begin
				use_a  = instr[8];
				writes = !instr[8];
			end
			default: ;
		endcase
	end

	// scoreboard check over stages 2 to 4
	assign rd_mask = ({15'b0, use_a} << rd_a) | ({15'b0, use_b} << rd_b);
	assign pending = pend2_q | pend3_q | pend4_q;
	assign stall   = |(rd_mask & pending);

	always_comb begin
		next_issue.cls    = stall ? OP_NOP : cls;
		next_issue.alu_op = alu_op_e'(instr[10:8]);
		next_issue.dest   = dst;
		next_issue.imm    = {prefix_q, instr[3:0]};
		next_issue.store  = instr[8];
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			prefix_q   <= '0;
			pend2_q    <= '0;
			pend3_q    <= '0;
			pend4_q    <= '0;
			issued.cls <= OP_NOP;
		end else begin
			pend2_q <= (writes && !stall) ? (16'b1 << dst) : '0;
			pend3_q <= pend2_q;
			pend4_q <= pend3_q;
			issued  <= next_issue;
			// nops and bubbles leave the prefix alone
			if (!stall) begin
				if (cls == OP_IMM)
					prefix_q <= instr[DATA_W-5:0];
				else if (cls != OP_NOP)
					prefix_q <= '0;
			end
		end
	end

	// a stalled word stays in stage 1 while a bubble goes down the pipe
	a_stall_bubble: assert property (@(posedge CLK) disable iff (!RSTb)
		stall |=> (issued.cls == OP_NOP) && $stable(instr));

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter logic [DATA_W-1:0] RESET_PC = '0
) (
	input  wire logic  CLK,
	input  wire logic  RSTb,
	input  wire word_t mem_rdata,
	input  wire logic  stall,
	input  wire logic  port_busy,
	input  wire logic  load_return,
	output word_t      fetch_addr,
	output word_t      instr
);

	logic [DATA_W-1:0] pc_q;
	logic [DATA_W-1:0] replay_q;
	logic [DATA_W-1:0] fetch_pc;
	logic              live_q;
	logic              arrive_ok;

	// word in mem_rdata is an instruction only after a real fetch
	assign arrive_ok = live_q && !load_return;

	// a stall drops the arriving word, so ask for it again right away
	assign fetch_pc = (stall && arrive_ok) ? replay_q : pc_q;
	assign fetch_addr = fetch_pc;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc_q     <= RESET_PC;
			replay_q <= RESET_PC;
			live_q   <= 1'b0;
			instr    <= '0;
		end else begin
			live_q   <= 1'b1;
			replay_q <= fetch_pc;
			// data access owns the port, this fetch never went out
			if (port_busy)
				pc_q <= fetch_pc;
			else
				pc_q <= fetch_pc + {{(DATA_W-1){1'b0}}, 1'b1};
			// hold on stall, squash data words into a nop
			if (!stall)
				instr <= arrive_ok ? mem_rdata : '0;
		end
	end

	// a fetch pushed off the port goes out on the next cycle
	a_steal_refetch: assert property (@(posedge CLK) disable iff (!RSTb)
		port_busy |=> fetch_addr == $past(fetch_addr));

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire reg_idx_t rd_a,
	input  wire reg_idx_t rd_b,
	input  wire wb_t      wb,
	output word_t         data_a,
	output word_t         data_b
);

	logic [DATA_W-1:0] regs [16];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.idx] <= wb.data;
		end
	end

	// read data shows up one cycle after the index, old value on a same-cycle write
	always_ff @(posedge CLK) begin
		data_a <= regs[rd_a];
		data_b <= regs[rd_b];
	end

	a_wb_en_known: assert property (@(posedge CLK) disable iff (!RSTb)
		!$isunknown(wb.en));

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  wire alu_op_e op,
	input  wire word_t   a,
	input  wire word_t   b,
	output word_t        y
);

	always_comb begin
		y = b;
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			ALU_XOR: y = a ^ b;
			// single-bit shifts of A, B unused
			ALU_SHL: y = {a[DATA_W-2:0], 1'b0};
			ALU_SHR: y = {1'b0, a[DATA_W-1:1]};
			ALU_PASS_B: y = b;
			default: y = b;
		endcase
	end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// one data or address word
	typedef logic [15:0] word_t;

	// register index, sixteen general registers
	typedef logic [3:0] reg_idx_t;

	// instruction classes after decode
	typedef enum logic [2:0] {
		OP_NOP,
		OP_INC,
		OP_DEC,
		OP_IMM,
		OP_ALU_RR,
		OP_ALU_RI,
		OP_MEM_REG,
		OP_MEM_IMM
	} op_class_e;

	// alu operation, straight from instruction bits [10:8]
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B
	} alu_op_e;

	// stage 2 payload
	typedef struct packed {
		op_class_e cls;
		alu_op_e   alu_op;
		reg_idx_t  dest;
		word_t     imm;
		logic      store;
	} issue_t;

	// stage 3 payload, also kept in stage 4
	typedef struct packed {
		op_class_e cls;
		reg_idx_t  dest;
		word_t     result;
		word_t     addr;
		word_t     sdata;
		logic      store;
	} ex_t;

	// register write request
	typedef struct packed {
		logic     en;
		reg_idx_t idx;
		word_t    data;
	} wb_t;

	// memory port request
	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  we;
	} mem_req_t;

endpackage

`default_nettype wire
